/* rtl/dual_issue_pkg.sv */
`default_nettype none

package dual_issue_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int INST_W = 32;
    localparam int PC_W   = 32;
    localparam int REG_W  = 5;

    // Field positions inside the instruction word
    localparam int CLASS_MSB = 31;
    localparam int CLASS_LSB = 28;
    localparam int RK_LSB    = 10;
    localparam int RJ_LSB    = 5;
    localparam int RD_LSB    = 0;

    ////////////////////////////////////////
    // Instruction classes
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        CLS_ALU    = 4'd0,
        CLS_BRANCH = 4'd1,
        CLS_LOAD   = 4'd2,
        CLS_STORE  = 4'd3,
        CLS_MUL    = 4'd4,
        CLS_DIV    = 4'd5,
        CLS_CSR    = 4'd6,
        CLS_RDCNT  = 4'd7,
        CLS_CACOP  = 4'd8,
        CLS_EXCEPT = 4'd9
    } inst_class_e;

    // Result arrives after the next issue slot
    function automatic logic class_writes_late(input inst_class_e cls);
        case (cls)
            CLS_LOAD, CLS_MUL, CLS_DIV, CLS_RDCNT: return 1'b1;
            default:                               return 1'b0;
        endcase
    endfunction

    // Unknown encodings fall into the default arm, same as ALU
    function automatic logic class_writes_rd(input inst_class_e cls);
        case (cls)
            CLS_BRANCH, CLS_STORE, CLS_CACOP, CLS_EXCEPT: return 1'b0;
            default:                                      return 1'b1;
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/issue_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                              clk,
    input  wire                              i_rst_n,
    input  wire                              i_flush,
    input  wire  [1:0]                       i_push_valid,
    input  wire  [dual_issue_pkg::INST_W-1:0] i_push_inst_a,
    input  wire  [dual_issue_pkg::INST_W-1:0] i_push_inst_b,
    input  wire  [dual_issue_pkg::PC_W-1:0]   i_push_pc_a,
    input  wire  [dual_issue_pkg::PC_W-1:0]   i_push_pc_b,
    input  wire  [1:0]                       i_pop_count,
    output logic                             o_queue_room,
    output logic                             o_head_valid_a,
    output logic                             o_head_valid_b,
    output logic [dual_issue_pkg::INST_W-1:0] o_head_inst_a,
    output logic [dual_issue_pkg::INST_W-1:0] o_head_inst_b,
    output logic [dual_issue_pkg::PC_W-1:0]   o_head_pc_a,
    output logic [dual_issue_pkg::PC_W-1:0]   o_head_pc_b
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [dual_issue_pkg::INST_W-1:0] inst_mem [QUEUE_DEPTH];
    logic [dual_issue_pkg::PC_W-1:0]   pc_mem   [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_b;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_b;
    logic [CNT_W-1:0] count;
    logic [1:0]       push_num;

    logic [dual_issue_pkg::INST_W-1:0] first_inst;
    logic [dual_issue_pkg::PC_W-1:0]   first_pc;

    // Room means two free slots, so a full pair always fits
    assign o_queue_room = (count <= CNT_W'(QUEUE_DEPTH - 2));
    assign push_num     = o_queue_room ? ({1'b0, i_push_valid[1]} + {1'b0, i_push_valid[0]})
                                       : 2'd0;

    assign wr_ptr_b = wr_ptr + 1'b1;
    assign rd_ptr_b = rd_ptr + 1'b1;

    // A lone slot B push lands in the first free entry
    assign first_inst = i_push_valid[1] ? i_push_inst_a : i_push_inst_b;
    assign first_pc   = i_push_valid[1] ? i_push_pc_a   : i_push_pc_b;

    ////////////////////////////////////////
    // Storage write
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (push_num != 2'd0 && !i_flush) begin
            inst_mem[wr_ptr] <= first_inst;
            pc_mem[wr_ptr]   <= first_pc;
            if (push_num == 2'd2) begin
                inst_mem[wr_ptr_b] <= i_push_inst_b;
                pc_mem[wr_ptr_b]   <= i_push_pc_b;
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_num);
            rd_ptr <= rd_ptr + PTR_W'(i_pop_count);
            count  <= count + CNT_W'(push_num) - CNT_W'(i_pop_count);
        end
    end

    ////////////////////////////////////////
    // Head entries, read combinationally
    ////////////////////////////////////////
    assign o_head_valid_a = (count != '0);
    assign o_head_valid_b = (count > CNT_W'(1));
    assign o_head_inst_a  = inst_mem[rd_ptr];
    assign o_head_inst_b  = inst_mem[rd_ptr_b];
    assign o_head_pc_a    = pc_mem[rd_ptr];
    assign o_head_pc_b    = pc_mem[rd_ptr_b];

endmodule

`default_nettype wire

/* rtl/inst_classify.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_classify (
    input  wire  [dual_issue_pkg::INST_W-1:0] i_inst,
    output logic                             o_is_alu,
    output logic                             o_is_branch,
    output logic                             o_is_store,
    output logic                             o_is_cacop,
    output logic                             o_is_except,
    output logic                             o_writes_late,
    output logic [dual_issue_pkg::REG_W-1:0]  o_rd,
    output logic [dual_issue_pkg::REG_W-1:0]  o_rj,
    output logic [dual_issue_pkg::REG_W-1:0]  o_rk
);

    logic [3:0]                  raw_class;
    dual_issue_pkg::inst_class_e cls;

    assign raw_class = i_inst[dual_issue_pkg::CLASS_MSB:dual_issue_pkg::CLASS_LSB];

    // Unused encodings decode as ALU
    always_comb begin
        case (raw_class)
            dual_issue_pkg::CLS_BRANCH, dual_issue_pkg::CLS_LOAD,
            dual_issue_pkg::CLS_STORE,  dual_issue_pkg::CLS_MUL,
            dual_issue_pkg::CLS_DIV,    dual_issue_pkg::CLS_CSR,
            dual_issue_pkg::CLS_RDCNT,  dual_issue_pkg::CLS_CACOP,
            dual_issue_pkg::CLS_EXCEPT: cls = dual_issue_pkg::inst_class_e'(raw_class);
            default:                    cls = dual_issue_pkg::CLS_ALU;
        endcase
    end

    assign o_is_alu      = (cls == dual_issue_pkg::CLS_ALU);
    assign o_is_branch   = (cls == dual_issue_pkg::CLS_BRANCH);
    assign o_is_store    = (cls == dual_issue_pkg::CLS_STORE);
    assign o_is_cacop    = (cls == dual_issue_pkg::CLS_CACOP);
    assign o_is_except   = (cls == dual_issue_pkg::CLS_EXCEPT);
    assign o_writes_late = dual_issue_pkg::class_writes_late(cls);

    // rd reads as r0 for non-writers
    assign o_rd = dual_issue_pkg::class_writes_rd(cls)
                ? i_inst[dual_issue_pkg::RD_LSB +: dual_issue_pkg::REG_W] : '0;
    assign o_rj = i_inst[dual_issue_pkg::RJ_LSB +: dual_issue_pkg::REG_W];
    assign o_rk = i_inst[dual_issue_pkg::RK_LSB +: dual_issue_pkg::REG_W];

endmodule

`default_nettype wire

/* rtl/pair_hazard_check.sv */
`timescale 1ns/1ns
`default_nettype none

module pair_hazard_check (
    input  wire                             i_a_is_alu,
    input  wire                             i_a_is_branch,
    input  wire                             i_a_is_except,
    input  wire [dual_issue_pkg::REG_W-1:0] i_a_rd,
    input  wire                             i_b_is_branch,
    input  wire                             i_b_is_store,
    input  wire                             i_b_is_cacop,
    input  wire [dual_issue_pkg::REG_W-1:0] i_b_rj,
    input  wire [dual_issue_pkg::REG_W-1:0] i_b_rk,
    output logic                            o_pair_conflict
);

    logic a_not_alu;
    logic double_branch;
    logic b_cacop;
    logic raw_hit;
    logic mem_after_redirect;

    ////////////////////////////////////////
    // Individual pairing rules
    ////////////////////////////////////////

    // Slot B only takes plain ALU leaders
    assign a_not_alu = ~i_a_is_alu;

    // One branch unit
    assign double_branch = i_a_is_branch & i_b_is_branch;

    // Cache ops always go alone from slot A
    assign b_cacop = i_b_is_cacop;

    // Same-cycle RAW, r0 never counts
    assign raw_hit = (i_a_rd != '0) && ((i_a_rd == i_b_rj) || (i_a_rd == i_b_rk));

    // Memory side effect must not slip past a redirect
    assign mem_after_redirect = (i_b_is_store | i_b_is_cacop)
                              & (i_a_is_branch | i_a_is_except);

    assign o_pair_conflict = a_not_alu
                           | double_branch
                           | b_cacop
                           | raw_hit
                           | mem_after_redirect;

endmodule

`default_nettype wire

/* rtl/issue_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_dispatch (
    input  wire                             clk,
    input  wire                             i_rst_n,
    input  wire                             i_stall,
    input  wire                             i_flush,
    input  wire                             i_valid_a,
    input  wire                             i_valid_b,
    input  wire                             i_a_writes_late,
    input  wire                             i_b_writes_late,
    input  wire [dual_issue_pkg::REG_W-1:0] i_a_rd,
    input  wire [dual_issue_pkg::REG_W-1:0] i_b_rd,
    input  wire [dual_issue_pkg::REG_W-1:0] i_a_rj,
    input  wire [dual_issue_pkg::REG_W-1:0] i_a_rk,
    input  wire [dual_issue_pkg::REG_W-1:0] i_b_rj,
    input  wire [dual_issue_pkg::REG_W-1:0] i_b_rk,
    input  wire                             i_pair_conflict,
    output logic [1:0]                      o_issue_count
);

    logic                             late_pending;
    logic [dual_issue_pkg::REG_W-1:0] late_reg;

    logic lock_a;
    logic lock_b;
    logic a_late;
    logic b_late;

    ////////////////////////////////////////
    // Load-use interlock check
    ////////////////////////////////////////
    assign lock_a = late_pending && ((late_reg == i_a_rj) || (late_reg == i_a_rk));
    assign lock_b = late_pending && ((late_reg == i_b_rj) || (late_reg == i_b_rk));

    // Issue decision, same cycle as the head
    always_comb begin
        if (i_stall || i_flush || !i_valid_a || lock_a) begin
            o_issue_count = 2'd0;
        end else if (!i_valid_b || lock_b || i_pair_conflict) begin
            o_issue_count = 2'd1;
        end else begin
            o_issue_count = 2'd2;
        end
    end

    // Issued late writers with a real destination
    assign a_late = (o_issue_count != 2'd0) && i_a_writes_late && (i_a_rd != '0);
    assign b_late = (o_issue_count == 2'd2) && i_b_writes_late && (i_b_rd != '0);

    ////////////////////////////////////////
    // Interlock state
    ////////////////////////////////////////

    // An issue-free cycle lets the pending result land
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            late_pending <= 1'b0;
        end else if (i_flush) begin
            late_pending <= 1'b0;
        end else if (!i_stall) begin
            late_pending <= a_late | b_late;
        end
    end

    // Only meaningful while late_pending is set
    always_ff @(posedge clk) begin
        if (a_late || b_late) begin
            late_reg <= a_late ? i_a_rd : i_b_rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/dual_issue_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dual_issue_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                               clk,
    input  wire                               i_rst_n,
    input  wire                               i_flush,
    input  wire                               i_stall,
    input  wire  [1:0]                        i_push_valid,
    input  wire  [dual_issue_pkg::INST_W-1:0] i_push_inst_a,
    input  wire  [dual_issue_pkg::INST_W-1:0] i_push_inst_b,
    input  wire  [dual_issue_pkg::PC_W-1:0]   i_push_pc_a,
    input  wire  [dual_issue_pkg::PC_W-1:0]   i_push_pc_b,
    output logic                              o_queue_room,
    output logic [1:0]                        o_issue_count,
    output logic [dual_issue_pkg::INST_W-1:0] o_issue_inst_a,
    output logic [dual_issue_pkg::INST_W-1:0] o_issue_inst_b,
    output logic [dual_issue_pkg::PC_W-1:0]   o_issue_pc_a,
    output logic [dual_issue_pkg::PC_W-1:0]   o_issue_pc_b
);

    logic head_valid_a;
    logic head_valid_b;

    // Slot A flags
    logic                             a_is_alu;
    logic                             a_is_branch;
    logic                             a_is_except;
    logic                             a_writes_late;
    logic [dual_issue_pkg::REG_W-1:0] a_rd;
    logic [dual_issue_pkg::REG_W-1:0] a_rj;
    logic [dual_issue_pkg::REG_W-1:0] a_rk;

    // Slot B flags
    logic                             b_is_branch;
    logic                             b_is_store;
    logic                             b_is_cacop;
    logic                             b_writes_late;
    logic [dual_issue_pkg::REG_W-1:0] b_rd;
    logic [dual_issue_pkg::REG_W-1:0] b_rj;
    logic [dual_issue_pkg::REG_W-1:0] b_rk;

    logic pair_conflict;

    ////////////////////////////////////////
    // Queue, head goes straight out
    ////////////////////////////////////////
    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue_queue (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .i_push_valid   (i_push_valid),
        .i_push_inst_a  (i_push_inst_a),
        .i_push_inst_b  (i_push_inst_b),
        .i_push_pc_a    (i_push_pc_a),
        .i_push_pc_b    (i_push_pc_b),
        .i_pop_count    (o_issue_count),
        .o_queue_room   (o_queue_room),
        .o_head_valid_a (head_valid_a),
        .o_head_valid_b (head_valid_b),
        .o_head_inst_a  (o_issue_inst_a),
        .o_head_inst_b  (o_issue_inst_b),
        .o_head_pc_a    (o_issue_pc_a),
        .o_head_pc_b    (o_issue_pc_b)
    );

    inst_classify classify_a (
        .i_inst        (o_issue_inst_a),
        .o_is_alu      (a_is_alu),
        .o_is_branch   (a_is_branch),
        .o_is_store    (),
        .o_is_cacop    (),
        .o_is_except   (a_is_except),
        .o_writes_late (a_writes_late),
        .o_rd          (a_rd),
        .o_rj          (a_rj),
        .o_rk          (a_rk)
    );

    inst_classify classify_b (
        .i_inst        (o_issue_inst_b),
        .o_is_alu      (),
        .o_is_branch   (b_is_branch),
        .o_is_store    (b_is_store),
        .o_is_cacop    (b_is_cacop),
        .o_is_except   (),
        .o_writes_late (b_writes_late),
        .o_rd          (b_rd),
        .o_rj          (b_rj),
        .o_rk          (b_rk)
    );

    pair_hazard_check u_pair_hazard_check (
        .i_a_is_alu      (a_is_alu),
        .i_a_is_branch   (a_is_branch),
        .i_a_is_except   (a_is_except),
        .i_a_rd          (a_rd),
        .i_b_is_branch   (b_is_branch),
        .i_b_is_store    (b_is_store),
        .i_b_is_cacop    (b_is_cacop),
        .i_b_rj          (b_rj),
        .i_b_rk          (b_rk),
        .o_pair_conflict (pair_conflict)
    );

    // Count feeds back to the queue as its pop amount
    issue_dispatch u_issue_dispatch (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_stall         (i_stall),
        .i_flush         (i_flush),
        .i_valid_a       (head_valid_a),
        .i_valid_b       (head_valid_b),
        .i_a_writes_late (a_writes_late),
        .i_b_writes_late (b_writes_late),
        .i_a_rd          (a_rd),
        .i_b_rd          (b_rd),
        .i_a_rj          (a_rj),
        .i_a_rk          (a_rk),
        .i_b_rj          (b_rj),
        .i_b_rk          (b_rk),
        .i_pair_conflict (pair_conflict),
        .o_issue_count   (o_issue_count)
    );

endmodule

`default_nettype wire

/* dv/tb_dual_issue.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dual_issue;

    localparam int DEPTH        = 8;
    localparam int SEED         = 89;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 300;
    localparam int DRAIN_LIMIT  = 40;

    // Budget per test from reset through the random stream
    localparam int TEST_CYCLES    = RESET_CYCLES + 20 + 80 + 30 + 30 + 30 + RAND_CYCLES + 60;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;

    logic        clk;
    logic        i_rst_n;
    logic        i_flush;
    logic        i_stall;
    logic [1:0]  i_push_valid;
    logic [31:0] i_push_inst_a;
    logic [31:0] i_push_inst_b;
    logic [31:0] i_push_pc_a;
    logic [31:0] i_push_pc_b;
    logic        o_queue_room;
    logic [1:0]  o_issue_count;
    logic [31:0] o_issue_inst_a;
    logic [31:0] o_issue_inst_b;
    logic [31:0] o_issue_pc_a;
    logic [31:0] o_issue_pc_b;

    // Reference queue and interlock state
    logic [31:0] mq_inst[$];
    logic [31:0] mq_pc[$];
    logic        m_late;
    logic [4:0]  m_late_reg;

    // Expected values settle at the falling edge
    logic [1:0]  exp_count;
    logic        exp_room;
    logic        exp_valid_a;
    logic        exp_valid_b;
    logic [31:0] exp_inst_a;
    logic [31:0] exp_inst_b;
    logic [31:0] exp_pc_a;
    logic [31:0] exp_pc_b;

    string       test_name;
    int          err_count;
    int          test_err_start;
    int          pass_tests;
    int          fail_tests;
    int          cycle_count;
    int          pushed_total;
    int          issued_total;
    logic [31:0] next_pc;

    dual_issue_top #(
        .QUEUE_DEPTH (DEPTH)
    ) uut (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .i_stall        (i_stall),
        .i_push_valid   (i_push_valid),
        .i_push_inst_a  (i_push_inst_a),
        .i_push_inst_b  (i_push_inst_b),
        .i_push_pc_a    (i_push_pc_a),
        .i_push_pc_b    (i_push_pc_b),
        .o_queue_room   (o_queue_room),
        .o_issue_count  (o_issue_count),
        .o_issue_inst_a (o_issue_inst_a),
        .o_issue_inst_b (o_issue_inst_b),
        .o_issue_pc_a   (o_issue_pc_a),
        .o_issue_pc_b   (o_issue_pc_b)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Instruction helpers
    ////////////////////////////////////////
    function automatic logic [31:0] encode(input logic [3:0] cls, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        logic [12:0] imm;
        imm = 13'($urandom);
        return {cls, imm, rk, rj, rd};
    endfunction

    // Unknown class encodings behave as ALU
    function automatic dual_issue_pkg::inst_class_e decoded_class(input logic [31:0] inst);
        logic [3:0] raw;
        raw = inst[dual_issue_pkg::CLASS_MSB:dual_issue_pkg::CLASS_LSB];
        if (raw > 4'd9) begin
            return dual_issue_pkg::CLS_ALU;
        end
        return dual_issue_pkg::inst_class_e'(raw);
    endfunction

    function automatic logic [4:0] dest_of(input logic [31:0] inst);
        if (dual_issue_pkg::class_writes_rd(decoded_class(inst))) begin
            return inst[dual_issue_pkg::RD_LSB +: dual_issue_pkg::REG_W];
        end
        return 5'd0;
    endfunction

    function automatic logic [4:0] rj_of(input logic [31:0] inst);
        return inst[dual_issue_pkg::RJ_LSB +: dual_issue_pkg::REG_W];
    endfunction

    function automatic logic [4:0] rk_of(input logic [31:0] inst);
        return inst[dual_issue_pkg::RK_LSB +: dual_issue_pkg::REG_W];
    endfunction

    function automatic logic waits_on_load(input logic [31:0] inst);
        return m_late && (m_late_reg == rj_of(inst) || m_late_reg == rk_of(inst));
    endfunction

    function automatic logic late_writer(input logic [31:0] inst);
        return dual_issue_pkg::class_writes_late(decoded_class(inst)) && dest_of(inst) != 5'd0;
    endfunction

    // Reasons a pair cannot go out together
    function automatic logic cannot_pair(input logic [31:0] a, input logic [31:0] b);
        dual_issue_pkg::inst_class_e ca;
        dual_issue_pkg::inst_class_e cb;
        logic                        raw;
        ca  = decoded_class(a);
        cb  = decoded_class(b);
        raw = dest_of(a) != 5'd0 && (dest_of(a) == rj_of(b) || dest_of(a) == rk_of(b));
        if (ca != dual_issue_pkg::CLS_ALU || cb == dual_issue_pkg::CLS_CACOP || raw) begin
            return 1'b1;
        end
        if (ca == dual_issue_pkg::CLS_BRANCH && cb == dual_issue_pkg::CLS_BRANCH) begin
            return 1'b1;
        end
        return (cb == dual_issue_pkg::CLS_STORE)
            && (ca == dual_issue_pkg::CLS_BRANCH || ca == dual_issue_pkg::CLS_EXCEPT);
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    always @(negedge clk) begin
        exp_room    = mq_inst.size() <= DEPTH - 2;
        exp_valid_a = mq_inst.size() > 0;
        exp_valid_b = mq_inst.size() > 1;
        exp_inst_a  = exp_valid_a ? mq_inst[0] : 32'd0;
        exp_pc_a    = exp_valid_a ? mq_pc[0] : 32'd0;
        exp_inst_b  = exp_valid_b ? mq_inst[1] : 32'd0;
        exp_pc_b    = exp_valid_b ? mq_pc[1] : 32'd0;
        if (i_stall || i_flush || !exp_valid_a || waits_on_load(exp_inst_a)) begin
            exp_count = 2'd0;
        end else if (!exp_valid_b || waits_on_load(exp_inst_b)
                     || cannot_pair(exp_inst_a, exp_inst_b)) begin
            exp_count = 2'd1;
        end else begin
            exp_count = 2'd2;
        end
        // Entries the DUT retires at the coming edge
        issued_total += o_issue_count;
    end

    always @(posedge clk) begin
        logic a_late;
        logic b_late;
        if (!i_rst_n || i_flush) begin
            mq_inst.delete();
            mq_pc.delete();
            m_late = 1'b0;
        end else begin
            // Interlock holds through a stall
            if (!i_stall) begin
                a_late = exp_count != 2'd0 && late_writer(exp_inst_a);
                b_late = exp_count == 2'd2 && late_writer(exp_inst_b);
                m_late = a_late || b_late;
                if (a_late) begin
                    m_late_reg = dest_of(exp_inst_a);
                end else if (b_late) begin
                    m_late_reg = dest_of(exp_inst_b);
                end
            end
            repeat (exp_count) begin
                void'(mq_inst.pop_front());
                void'(mq_pc.pop_front());
            end
            if (exp_room && i_push_valid[1]) begin
                mq_inst.push_back(i_push_inst_a);
                mq_pc.push_back(i_push_pc_a);
                pushed_total++;
            end
            if (exp_room && i_push_valid[0]) begin
                mq_inst.push_back(i_push_inst_b);
                mq_pc.push_back(i_push_pc_b);
                pushed_total++;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic log_mismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
        err_count++;
    endtask

    count_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_issue_count == exp_count)
        else log_mismatch("issue count", $sampled(exp_count), $sampled(o_issue_count));

    room_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_queue_room == exp_room)
        else log_mismatch("queue room", $sampled(exp_room), $sampled(o_queue_room));

    inst_a_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        exp_valid_a |-> o_issue_inst_a == exp_inst_a)
        else log_mismatch("slot a word", $sampled(exp_inst_a), $sampled(o_issue_inst_a));

    pc_a_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        exp_valid_a |-> o_issue_pc_a == exp_pc_a)
        else log_mismatch("slot a pc", $sampled(exp_pc_a), $sampled(o_issue_pc_a));

    inst_b_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        exp_valid_b |-> o_issue_inst_b == exp_inst_b)
        else log_mismatch("slot b word", $sampled(exp_inst_b), $sampled(o_issue_inst_b));

    pc_b_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        exp_valid_b |-> o_issue_pc_b == exp_pc_b)
        else log_mismatch("slot b pc", $sampled(exp_pc_b), $sampled(o_issue_pc_b));

    // Hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic push_entries(input logic [1:0] valid, input logic [31:0] inst_a,
                                input logic [31:0] inst_b);
        i_push_valid  = valid;
        i_push_inst_a = inst_a;
        i_push_inst_b = inst_b;
        i_push_pc_a   = next_pc;
        i_push_pc_b   = next_pc + 32'd4;
        next_pc       = next_pc + 32'd8;
        step();
        i_push_valid  = 2'b00;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (mq_inst.size() != 0 && waited < DRAIN_LIMIT) begin
            step();
            waited++;
        end
        if (mq_inst.size() != 0) begin
            $display("error in %s: queue still holds entries after %0d cycles",
                     test_name, DRAIN_LIMIT);
            err_count++;
        end
    endtask

    task automatic pair_case(input logic [31:0] a, input logic [31:0] b);
        push_entries(2'b11, a, b);
        wait_drained();
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_count;
    endtask

    task automatic finish_test();
        if (err_count == test_err_start) begin
            $display("test %s: ok", test_name);
            pass_tests++;
        end else begin
            $display("test %s: %0d errors", test_name, err_count - test_err_start);
            fail_tests++;
        end
    endtask

    function automatic logic [31:0] random_inst();
        logic [3:0] cls;
        cls = 4'($urandom % 16);
        return encode(cls, 5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8));
    endfunction

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(SEED));
        clk           = 1'b0;
        i_rst_n       = 1'b0;
        i_flush       = 1'b0;
        i_stall       = 1'b0;
        i_push_valid  = 2'b00;
        i_push_inst_a = '0;
        i_push_inst_b = '0;
        i_push_pc_a   = '0;
        i_push_pc_b   = '0;
        m_late        = 1'b0;
        m_late_reg    = '0;
        exp_count     = '0;
        err_count     = 0;
        pass_tests    = 0;
        fail_tests    = 0;
        cycle_count   = 0;
        pushed_total  = 0;
        issued_total  = 0;
        next_pc       = 32'h1c00_0000;
        test_name     = "reset";

        repeat (RESET_CYCLES) @(posedge clk);
        #1 i_rst_n = 1'b1;

        // 1. Reset state and lone pushes on either slot
        start_test("reset_single");
        assert (o_issue_count == 2'd0) else log_mismatch("count after reset", 0, o_issue_count);
        assert (o_queue_room == 1'b1) else log_mismatch("room after reset", 1, o_queue_room);
        push_entries(2'b10, encode(dual_issue_pkg::CLS_ALU, 5'd1, 5'd2, 5'd3), '0);
        wait_drained();
        push_entries(2'b01, '0, encode(dual_issue_pkg::CLS_ALU, 5'd4, 5'd5, 5'd6));
        wait_drained();
        finish_test();

        // 2. Each pairing rule plus clean pairs
        start_test("pair_rules");
        pair_case(encode(dual_issue_pkg::CLS_LOAD, 5'd1, 5'd2, 5'd3),
                  encode(dual_issue_pkg::CLS_ALU, 5'd4, 5'd6, 5'd7));
        pair_case(encode(dual_issue_pkg::CLS_BRANCH, 5'd0, 5'd2, 5'd3),
                  encode(dual_issue_pkg::CLS_BRANCH, 5'd0, 5'd4, 5'd6));
        pair_case(encode(dual_issue_pkg::CLS_ALU, 5'd1, 5'd2, 5'd3),
                  encode(dual_issue_pkg::CLS_CACOP, 5'd0, 5'd4, 5'd6));
        pair_case(encode(dual_issue_pkg::CLS_ALU, 5'd3, 5'd1, 5'd2),
                  encode(dual_issue_pkg::CLS_ALU, 5'd4, 5'd3, 5'd6));
        pair_case(encode(dual_issue_pkg::CLS_ALU, 5'd3, 5'd1, 5'd2),
                  encode(dual_issue_pkg::CLS_ALU, 5'd4, 5'd6, 5'd3));
        pair_case(encode(dual_issue_pkg::CLS_BRANCH, 5'd0, 5'd1, 5'd2),
                  encode(dual_issue_pkg::CLS_STORE, 5'd0, 5'd4, 5'd6));
        pair_case(encode(dual_issue_pkg::CLS_EXCEPT, 5'd0, 5'd0, 5'd0),
                  encode(dual_issue_pkg::CLS_STORE, 5'd0, 5'd4, 5'd6));
        pair_case(encode(dual_issue_pkg::CLS_ALU, 5'd0, 5'd1, 5'd2),
                  encode(dual_issue_pkg::CLS_ALU, 5'd4, 5'd0, 5'd0));
        pair_case(encode(dual_issue_pkg::CLS_ALU, 5'd1, 5'd2, 5'd3),
                  encode(dual_issue_pkg::CLS_STORE, 5'd0, 5'd4, 5'd6));
        pair_case(encode(dual_issue_pkg::CLS_ALU, 5'd1, 5'd2, 5'd3),
                  encode(dual_issue_pkg::CLS_BRANCH, 5'd0, 5'd4, 5'd6));
        finish_test();

        // 3. Load-use with the consumer in A and in B, then a load to r0
        start_test("load_use");
        pair_case(encode(dual_issue_pkg::CLS_LOAD, 5'd5, 5'd1, 5'd2),
                  encode(dual_issue_pkg::CLS_ALU, 5'd6, 5'd5, 5'd2));
        push_entries(2'b11, encode(dual_issue_pkg::CLS_LOAD, 5'd5, 5'd1, 5'd2),
                     encode(dual_issue_pkg::CLS_ALU, 5'd7, 5'd1, 5'd2));
        push_entries(2'b10, encode(dual_issue_pkg::CLS_ALU, 5'd8, 5'd3, 5'd5), '0);
        wait_drained();
        pair_case(encode(dual_issue_pkg::CLS_LOAD, 5'd0, 5'd1, 5'd2),
                  encode(dual_issue_pkg::CLS_ALU, 5'd6, 5'd0, 5'd0));
        finish_test();

        // 4. Stall right after a load retires
        start_test("stall");
        push_entries(2'b11, encode(dual_issue_pkg::CLS_LOAD, 5'd5, 5'd1, 5'd2),
                     encode(dual_issue_pkg::CLS_ALU, 5'd6, 5'd5, 5'd2));
        step();
        i_stall = 1'b1;
        repeat (4) step();
        i_stall = 1'b0;
        wait_drained();
        finish_test();

        // 5. Flush with entries queued and then with the interlock set
        start_test("flush");
        push_entries(2'b11, encode(dual_issue_pkg::CLS_DIV, 5'd9, 5'd1, 5'd2),
                     encode(dual_issue_pkg::CLS_ALU, 5'd6, 5'd9, 5'd2));
        push_entries(2'b11, random_inst(), random_inst());
        i_flush = 1'b1;
        push_entries(2'b11, random_inst(), random_inst());
        i_flush = 1'b0;
        pair_case(encode(dual_issue_pkg::CLS_ALU, 5'd1, 5'd2, 5'd3),
                  encode(dual_issue_pkg::CLS_ALU, 5'd4, 5'd6, 5'd7));
        push_entries(2'b10, encode(dual_issue_pkg::CLS_LOAD, 5'd5, 5'd1, 5'd2), '0);
        step();
        i_flush = 1'b1;
        step();
        i_flush = 1'b0;
        push_entries(2'b10, encode(dual_issue_pkg::CLS_ALU, 5'd6, 5'd5, 5'd5), '0);
        wait_drained();
        finish_test();

        // 6. Random stream with room-gated pushes and random stalls
        start_test("random_stream");
        pushed_total = 0;
        issued_total = 0;
        for (int i = 0; i < RAND_CYCLES; i++) begin
            i_stall       = ($urandom % 4) == 0;
            i_push_valid  = o_queue_room ? 2'($urandom) : 2'b00;
            i_push_inst_a = random_inst();
            i_push_inst_b = random_inst();
            i_push_pc_a   = next_pc;
            i_push_pc_b   = next_pc + 32'd4;
            next_pc       = next_pc + 32'd8;
            step();
        end
        i_stall      = 1'b0;
        i_push_valid = 2'b00;
        wait_drained();
        assert (issued_total == pushed_total)
            else log_mismatch("issued total", pushed_total, issued_total);
        finish_test();

        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/dual_issue_pkg.sv
rtl/issue_queue.sv
rtl/inst_classify.sv
rtl/pair_hazard_check.sv
rtl/issue_dispatch.sv
rtl/dual_issue_top.sv
dv/tb_dual_issue.sv
